//--- source/net_pkg.sv
// Network configuration path: address types and the tagged command word

package net_pkg;

    // Width of the command payload, sized for the widest address
    localparam int CMD_DATA_BITS = 48;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // Ethernet MAC address
    typedef logic [47:0] mac_addr_t;

    // Command kinds carried through the slice chain
    // 2'b11 is unused and never issued by the arbiter
    typedef enum logic [1:0] {
        CMD_SET_IP     = 2'd0,
        CMD_SET_MAC    = 2'd1,
        CMD_ARP_LOOKUP = 2'd2
    } net_cmd_kind_t;

    // Tagged command word
    // IP values sit in the low 32 bits, upper bits are zero
    typedef struct packed {
        net_cmd_kind_t              kind;
        logic [CMD_DATA_BITS-1:0]   data;
    } net_cmd_t;

endpackage

//--- source/net_cmd_arbiter.sv
// Command arbiter: round-robin merge of IP, MAC and ARP requests into one tagged stream

`timescale 1ns/1ps

module net_cmd_arbiter (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Set IP address
    input  logic                    set_ip_valid,
    output logic                    set_ip_ready,
    input  net_pkg::ip_addr_t       set_ip_data,

    // Set MAC address
    input  logic                    set_mac_valid,
    output logic                    set_mac_ready,
    input  net_pkg::mac_addr_t      set_mac_data,

    // ARP lookup request
    input  logic                    arp_req_valid,
    output logic                    arp_req_ready,
    input  net_pkg::ip_addr_t       arp_req_data,

    // Merged command stream
    output logic                    cmd_valid,
    input  logic                    cmd_ready,
    output net_pkg::net_cmd_t       cmd
);

    logic [2:0]         req;
    logic [2:0]         grant;
    logic [1:0]         grant_idx;
    logic [1:0]         last_grant;
    logic               can_load;
    logic               load;
    net_pkg::net_cmd_t  next_cmd;

    assign req = {arp_req_valid, set_mac_valid, set_ip_valid};

    // Output register free now or emptied on this edge
    assign can_load = !cmd_valid || cmd_ready;
    assign load     = can_load && (|req);

    // First requester after the last one granted
    always_comb begin : grant_select
        int unsigned idx;
        grant     = '0;
        grant_idx = 2'd0;
        for (int unsigned off = 1; off <= 3; off++) begin
            idx = (32'(last_grant) + off) % 3;
            if (req[idx] && !(|grant)) begin
                grant[idx] = 1'b1;
                grant_idx  = 2'(idx);
            end
        end
    end

    // Idle channels see ready, so all readies are high out of reset
    assign set_ip_ready  = can_load && (grant[0] || !set_ip_valid);
    assign set_mac_ready = can_load && (grant[1] || !set_mac_valid);
    assign arp_req_ready = can_load && (grant[2] || !arp_req_valid);

    // Tag and widen the granted payload
    always_comb begin
        case (grant_idx)
            2'd0: begin
                next_cmd.kind = net_pkg::CMD_SET_IP;
                next_cmd.data = {{(net_pkg::CMD_DATA_BITS - $bits(net_pkg::ip_addr_t)){1'b0}},
                                 set_ip_data};
            end
            2'd1: begin
                next_cmd.kind = net_pkg::CMD_SET_MAC;
                next_cmd.data = set_mac_data;
            end
            default: begin
                next_cmd.kind = net_pkg::CMD_ARP_LOOKUP;
                next_cmd.data = {{(net_pkg::CMD_DATA_BITS - $bits(net_pkg::ip_addr_t)){1'b0}},
                                 arp_req_data};
            end
        endcase
    end

    // Pointer starts on ARP so the IP channel wins the first round
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            cmd_valid  <= 1'b0;
            last_grant <= 2'd2;
        end else if (load) begin
            cmd_valid  <= 1'b1;
            last_grant <= grant_idx;
        end else if (cmd_ready) begin
            cmd_valid  <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            cmd <= next_cmd;
        end
    end

    // Only one channel may hand over a command per cycle
    assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0({set_ip_valid && set_ip_ready,
                  set_mac_valid && set_mac_ready,
                  arp_req_valid && arp_req_ready}))
        else $error("arbiter accepted more than one request in a cycle");

endmodule

//--- source/net_reg_slice.sv
// Register slice: one valid/ready pipeline stage for an arbitrary payload type

`timescale 1ns/1ps

module net_reg_slice #(
    parameter type payload_t = logic [31:0]
) (
    input  logic        aclk,
    input  logic        aresetn,

    // Upstream side
    input  logic        s_valid,
    output logic        s_ready,
    input  payload_t    s_data,

    // Downstream side
    output logic        m_valid,
    input  logic        m_ready,
    output payload_t    m_data
);

    logic       full;
    payload_t   data_q;

    // Full stage can still take a new word when it drains on the same edge
    assign s_ready = !full || m_ready;

    assign m_valid = full;
    assign m_data  = data_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            full <= 1'b0;
        end else if (s_valid && s_ready) begin
            full <= 1'b1;
        end else if (m_ready) begin
            full <= 1'b0;
        end
    end

    // Payload register, loaded only on an upstream transfer
    always_ff @(posedge aclk) begin
        if (s_valid && s_ready) begin
            data_q <= s_data;
        end
    end

    // A stalled word must not change under the consumer
    assert property (@(posedge aclk) disable iff (!aresetn)
        (m_valid && !m_ready) |=> (m_valid && $stable(m_data)))
        else $error("slice output changed while stalled");

endmodule

//--- source/net_config_regs.sv
// Configuration registers: hold IP and MAC addresses and forward ARP lookups to the network side

`timescale 1ns/1ps

module net_config_regs (
    input  logic                    aclk,
    input  logic                    aresetn,

    // Command stream from the slice chain
    input  logic                    cmd_valid,
    output logic                    cmd_ready,
    input  net_pkg::net_cmd_t       cmd,

    // Current addresses
    output net_pkg::ip_addr_t       ip_addr,
    output net_pkg::mac_addr_t      mac_addr,

    // ARP lookups towards the network side
    output logic                    arp_out_valid,
    input  logic                    arp_out_ready,
    output net_pkg::ip_addr_t       arp_out_data
);

    logic               cmd_xfer;
    logic               arp_full;
    logic               arp_load;
    net_pkg::ip_addr_t  arp_data_q;

    // Stall every command while a lookup waits, which keeps the stream in order
    assign cmd_ready = !arp_full || arp_out_ready;
    assign cmd_xfer  = cmd_valid && cmd_ready;
    assign arp_load  = cmd_xfer && (cmd.kind == net_pkg::CMD_ARP_LOOKUP);

    assign arp_out_valid = arp_full;
    assign arp_out_data  = arp_data_q;

    // Address registers
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ip_addr  <= '0;
            mac_addr <= '0;
        end else if (cmd_xfer) begin
            case (cmd.kind)
                net_pkg::CMD_SET_IP: begin
                    ip_addr <= cmd.data[$bits(net_pkg::ip_addr_t)-1:0];
                end
                net_pkg::CMD_SET_MAC: begin
                    mac_addr <= cmd.data;
                end
                default: begin
                    // ARP lookups leave both addresses alone
                end
            endcase
        end
    end

    // One-entry lookup buffer
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arp_full <= 1'b0;
        end else if (arp_load) begin
            arp_full <= 1'b1;
        end else if (arp_out_ready) begin
            arp_full <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (arp_load) begin
            arp_data_q <= cmd.data[$bits(net_pkg::ip_addr_t)-1:0];
        end
    end

    // Arbiter tagging and slice chain must never deliver the unused code
    assert property (@(posedge aclk) disable iff (!aresetn)
        cmd_xfer |-> (cmd.kind inside {net_pkg::CMD_SET_IP,
                                       net_pkg::CMD_SET_MAC,
                                       net_pkg::CMD_ARP_LOOKUP}))
        else $error("command with unknown kind reached the config registers");

endmodule

//--- source/net_config_top.sv
// Network configuration top: arbiter, register slice chain and configuration registers on aclk

`timescale 1ns/1ps

module net_config_top #(
    parameter int N_STAGES = 3
) (
    input  logic                    aclk,
    input  logic                    aresetn,

    // User command channels
    input  logic                    set_ip_valid,
    output logic                    set_ip_ready,
    input  net_pkg::ip_addr_t       set_ip_data,

    input  logic                    set_mac_valid,
    output logic                    set_mac_ready,
    input  net_pkg::mac_addr_t      set_mac_data,

    input  logic                    arp_req_valid,
    output logic                    arp_req_ready,
    input  net_pkg::ip_addr_t       arp_req_data,

    // Current addresses
    output net_pkg::ip_addr_t       ip_addr,
    output net_pkg::mac_addr_t      mac_addr,

    // ARP lookups to the network side
    output logic                    arp_out_valid,
    input  logic                    arp_out_ready,
    output net_pkg::ip_addr_t       arp_out_data
);

    // Chain links, index 0 is the arbiter output, N_STAGES feeds the registers
    logic [N_STAGES:0]  stg_valid;
    logic [N_STAGES:0]  stg_ready;
    net_pkg::net_cmd_t  stg_data [0:N_STAGES];

    net_cmd_arbiter inst_arbiter (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .set_ip_valid   (set_ip_valid),
        .set_ip_ready   (set_ip_ready),
        .set_ip_data    (set_ip_data),
        .set_mac_valid  (set_mac_valid),
        .set_mac_ready  (set_mac_ready),
        .set_mac_data   (set_mac_data),
        .arp_req_valid  (arp_req_valid),
        .arp_req_ready  (arp_req_ready),
        .arp_req_data   (arp_req_data),
        .cmd_valid      (stg_valid[0]),
        .cmd_ready      (stg_ready[0]),
        .cmd            (stg_data[0])
    );

    // Slice chain
    for (genvar i = 0; i < N_STAGES; i++) begin : gen_slice
        net_reg_slice #(
            .payload_t  (net_pkg::net_cmd_t)
        ) inst_slice (
            .aclk       (aclk),
            .aresetn    (aresetn),
            .s_valid    (stg_valid[i]),
            .s_ready    (stg_ready[i]),
            .s_data     (stg_data[i]),
            .m_valid    (stg_valid[i+1]),
            .m_ready    (stg_ready[i+1]),
            .m_data     (stg_data[i+1])
        );
    end

    net_config_regs inst_config_regs (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .cmd_valid      (stg_valid[N_STAGES]),
        .cmd_ready      (stg_ready[N_STAGES]),
        .cmd            (stg_data[N_STAGES]),
        .ip_addr        (ip_addr),
        .mac_addr       (mac_addr),
        .arp_out_valid  (arp_out_valid),
        .arp_out_ready  (arp_out_ready),
        .arp_out_data   (arp_out_data)
    );

endmodule

//--- bench/tb_net_config.sv
// Testbench for the network configuration top: directed command, ARP and back-pressure tests

`timescale 1ns/1ps

module tb_net_config;

    localparam int N_STAGES       = 3;
    localparam int TIMEOUT_CYCLES = 2000;
    // Out buffer, every slice and the arbiter register
    localparam int ARP_FILL       = N_STAGES + 2;
    localparam int STREAM_LEN     = 6;
    localparam int STREAM_LIMIT   = 3 * STREAM_LEN + N_STAGES + 4;

    logic                   aclk;
    logic                   aresetn;
    logic                   set_ip_valid;
    logic                   set_ip_ready;
    net_pkg::ip_addr_t      set_ip_data;
    logic                   set_mac_valid;
    logic                   set_mac_ready;
    net_pkg::mac_addr_t     set_mac_data;
    logic                   arp_req_valid;
    logic                   arp_req_ready;
    net_pkg::ip_addr_t      arp_req_data;
    net_pkg::ip_addr_t      ip_addr;
    net_pkg::mac_addr_t     mac_addr;
    logic                   arp_out_valid;
    logic                   arp_out_ready;
    net_pkg::ip_addr_t      arp_out_data;

    int                     cycle;
    int                     error_count;
    int                     tests_run;
    logic [31:0]            lcg_state;
    net_pkg::ip_addr_t      exp_ip;
    net_pkg::mac_addr_t     exp_mac;

    net_config_top #(
        .N_STAGES       (N_STAGES)
    ) UUT (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .set_ip_valid   (set_ip_valid),
        .set_ip_ready   (set_ip_ready),
        .set_ip_data    (set_ip_data),
        .set_mac_valid  (set_mac_valid),
        .set_mac_ready  (set_mac_ready),
        .set_mac_data   (set_mac_data),
        .arp_req_valid  (arp_req_valid),
        .arp_req_ready  (arp_req_ready),
        .arp_req_data   (arp_req_data),
        .ip_addr        (ip_addr),
        .mac_addr       (mac_addr),
        .arp_out_valid  (arp_out_valid),
        .arp_out_ready  (arp_out_ready),
        .arp_out_data   (arp_out_data)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // Counts rising edges, so at the drive point it holds the number of the last edge
    always @(posedge aclk) begin
        cycle <= cycle + 1;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("[ERROR] %s", msg);
    endtask

    task automatic tick();
        @(posedge aclk);
        #1;
    endtask

    // Called at the drive point with valid already up, returns at the drive point after
    // the handshake edge; ready is sampled late in the cycle once all drivers settled
    task automatic wait_handshake(input int chan, output int edge_no);
        logic rdy;
        rdy = 1'b0;
        while (!rdy) begin
            #2;
            case (chan)
                0: rdy = set_ip_ready;
                1: rdy = set_mac_ready;
                default: rdy = arp_req_ready;
            endcase
            @(posedge aclk);
            #1;
        end
        edge_no = cycle;
    endtask

    task automatic test_reset_state();
        tests_run++;
        exp_ip  = '0;
        exp_mac = '0;
        if (ip_addr !== exp_ip) report_mismatch("reset/ip_addr", 64'(exp_ip), 64'(ip_addr));
        if (mac_addr !== exp_mac) report_mismatch("reset/mac_addr", 64'(exp_mac), 64'(mac_addr));
        if (arp_out_valid !== 1'b0) report_mismatch("reset/arp_out_valid", 64'(0),
                                                    64'(arp_out_valid));
        if (set_ip_ready !== 1'b1) report_mismatch("reset/set_ip_ready", 64'(1),
                                                   64'(set_ip_ready));
        if (set_mac_ready !== 1'b1) report_mismatch("reset/set_mac_ready", 64'(1),
                                                    64'(set_mac_ready));
        if (arp_req_ready !== 1'b1) report_mismatch("reset/arp_req_ready", 64'(1),
                                                    64'(arp_req_ready));
    endtask

    // Address changes on the edge after the command leaves the last slice
    task automatic test_set_ip();
        net_pkg::ip_addr_t value;
        int hs_edge;
        tests_run++;
        value        = lcg_next();
        set_ip_data  = value;
        set_ip_valid = 1'b1;
        wait_handshake(0, hs_edge);
        set_ip_valid = 1'b0;
        while (cycle <= hs_edge + N_STAGES) begin
            if (ip_addr !== exp_ip) report_mismatch("set_ip/early", 64'(exp_ip), 64'(ip_addr));
            tick();
        end
        if (ip_addr !== value) report_mismatch("set_ip/ip_addr", 64'(value), 64'(ip_addr));
        if (mac_addr !== exp_mac) report_mismatch("set_ip/mac_addr", 64'(exp_mac),
                                                  64'(mac_addr));
        exp_ip = value;
    endtask

    task automatic test_set_mac();
        net_pkg::mac_addr_t value;
        logic [31:0] hi;
        int hs_edge;
        tests_run++;
        hi            = lcg_next();
        value         = {hi[15:0], lcg_next()};
        set_mac_data  = value;
        set_mac_valid = 1'b1;
        wait_handshake(1, hs_edge);
        set_mac_valid = 1'b0;
        while (cycle <= hs_edge + N_STAGES) begin
            if (mac_addr !== exp_mac) report_mismatch("set_mac/early", 64'(exp_mac),
                                                      64'(mac_addr));
            tick();
        end
        if (mac_addr !== value) report_mismatch("set_mac/mac_addr", 64'(value), 64'(mac_addr));
        if (ip_addr !== exp_ip) report_mismatch("set_mac/ip_addr", 64'(exp_ip), 64'(ip_addr));
        exp_mac = value;
    endtask

    task automatic test_arp_backpressure();
        net_pkg::ip_addr_t sent [ARP_FILL];
        net_pkg::ip_addr_t got [$];
        int hs_edge;
        int waited;
        tests_run++;
        arp_out_ready = 1'b0;
        for (int n = 0; n < ARP_FILL; n++) begin
            sent[n]       = lcg_next();
            arp_req_data  = sent[n];
            arp_req_valid = 1'b1;
            wait_handshake(2, hs_edge);
        end
        arp_req_valid = 1'b0;
        // Whole chain stalled behind the held lookup
        waited = 0;
        while (arp_req_ready && waited < 20) begin
            tick();
            waited++;
        end
        if (arp_req_ready) report_error("arp_backpressure: arp_req_ready never fell");
        if (arp_out_valid !== 1'b1) report_mismatch("arp_backpressure/valid", 64'(1),
                                                    64'(arp_out_valid));
        if (arp_out_data !== sent[0]) report_mismatch("arp_backpressure/first", 64'(sent[0]),
                                                      64'(arp_out_data));
        arp_out_ready = 1'b1;
        waited = 0;
        while (got.size() < ARP_FILL && waited < 50) begin
            #2;
            if (arp_out_valid) got.push_back(arp_out_data);
            @(posedge aclk);
            #1;
            waited++;
        end
        if (got.size() != ARP_FILL) report_error("arp_backpressure: lookups went missing");
        for (int n = 0; n < got.size(); n++) begin
            if (got[n] !== sent[n]) report_mismatch("arp_backpressure/order", 64'(sent[n]),
                                                    64'(got[n]));
        end
        // No duplicate left behind
        repeat (N_STAGES + 2) begin
            if (arp_out_valid) report_error("arp_backpressure: extra lookup after drain");
            tick();
        end
    endtask

    task automatic test_simultaneous();
        net_pkg::ip_addr_t  ip_vals [STREAM_LEN];
        net_pkg::mac_addr_t mac_vals [STREAM_LEN];
        net_pkg::ip_addr_t  arp_vals [STREAM_LEN];
        net_pkg::ip_addr_t  got [$];
        logic [31:0] hi;
        int start_cycle;
        int ip_last;
        int mac_last;
        int arp_last;
        int finish_cycle;
        tests_run++;
        for (int n = 0; n < STREAM_LEN; n++) begin
            ip_vals[n]  = lcg_next();
            hi          = lcg_next();
            mac_vals[n] = {hi[15:0], lcg_next()};
            arp_vals[n] = lcg_next();
        end
        arp_out_ready = 1'b1;
        start_cycle   = cycle;
        fork
            begin
                for (int n = 0; n < STREAM_LEN; n++) begin
                    set_ip_data  = ip_vals[n];
                    set_ip_valid = 1'b1;
                    wait_handshake(0, ip_last);
                end
                set_ip_valid = 1'b0;
            end
            begin
                for (int n = 0; n < STREAM_LEN; n++) begin
                    set_mac_data  = mac_vals[n];
                    set_mac_valid = 1'b1;
                    wait_handshake(1, mac_last);
                end
                set_mac_valid = 1'b0;
            end
            begin
                for (int n = 0; n < STREAM_LEN; n++) begin
                    arp_req_data  = arp_vals[n];
                    arp_req_valid = 1'b1;
                    wait_handshake(2, arp_last);
                end
                arp_req_valid = 1'b0;
            end
            begin : arp_sink
                int waited;
                waited = 0;
                while (got.size() < STREAM_LEN && waited < 100) begin
                    #2;
                    if (arp_out_valid) got.push_back(arp_out_data);
                    @(posedge aclk);
                    #1;
                    waited++;
                end
            end
        join
        finish_cycle = ip_last;
        if (mac_last > finish_cycle) finish_cycle = mac_last;
        if (arp_last > finish_cycle) finish_cycle = arp_last;
        if (finish_cycle - start_cycle > STREAM_LIMIT) begin
            report_error($sformatf("simultaneous: transfers took %0d cycles, limit is %0d",
                                   finish_cycle - start_cycle, STREAM_LIMIT));
        end
        repeat (N_STAGES + 2) tick();
        if (got.size() != STREAM_LEN) report_error("simultaneous: ARP lookups went missing");
        for (int n = 0; n < got.size(); n++) begin
            if (got[n] !== arp_vals[n]) report_mismatch("simultaneous/arp_order",
                                                         64'(arp_vals[n]), 64'(got[n]));
        end
        exp_ip  = ip_vals[STREAM_LEN-1];
        exp_mac = mac_vals[STREAM_LEN-1];
        if (ip_addr !== exp_ip) report_mismatch("simultaneous/ip_addr", 64'(exp_ip),
                                                64'(ip_addr));
        if (mac_addr !== exp_mac) report_mismatch("simultaneous/mac_addr", 64'(exp_mac),
                                                  64'(mac_addr));
    endtask

    initial begin
        cycle         = 0;
        error_count   = 0;
        tests_run     = 0;
        lcg_state     = 32'hb9caa8f7;
        aresetn       = 1'b0;
        set_ip_valid  = 1'b0;
        set_ip_data   = '0;
        set_mac_valid = 1'b0;
        set_mac_data  = '0;
        arp_req_valid = 1'b0;
        arp_req_data  = '0;
        arp_out_ready = 1'b0;
        repeat (16) @(posedge aclk);
        #1;
        aresetn = 1'b1;

        test_reset_state();
        test_set_ip();
        test_set_mac();
        test_arp_backpressure();
        test_simultaneous();

        $display("Summary: %0d tests run, %0d errors", tests_run, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/net_pkg.sv
source/net_cmd_arbiter.sv
source/net_reg_slice.sv
source/net_config_regs.sv
source/net_config_top.sv
bench/tb_net_config.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the configuration path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_net_config -f verilog.f -o sim_net_config \
    && ./obj_dir/sim_net_config | tee /dev/stderr | grep -q "Simulation finished: PASS" \
    && { echo "Run passed"; exit 0; } \
    || { echo "Run failed"; exit 1; }
